// ==== rtl/debug_ring.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dii_consts.svh"

module debug_ring
   import dii_pkg::*;
   #(parameter int PORTS       = 1,
     parameter int BUFFER_SIZE = `DII_BUFFER_DEPTH)
   (input  wire logic                             clk,
    input  wire logic                             rst_n,

    input  wire logic [PORTS*`DII_FLIT_WIDTH-1:0] in_data,
    input  wire logic [PORTS-1:0]                 in_valid,
    input  wire logic [PORTS-1:0]                 in_first,
    input  wire logic [PORTS-1:0]                 in_last,
    output wire logic [PORTS-1:0]                 in_ready,

    output wire logic [PORTS*`DII_FLIT_WIDTH-1:0] out_data,
    output wire logic [PORTS-1:0]                 out_valid,
    output wire logic [PORTS-1:0]                 out_first,
    output wire logic [PORTS-1:0]                 out_last,
    input  wire logic [PORTS-1:0]                 out_ready);

   localparam int W = `DII_FLIT_WIDTH;

   dii_flit_t lin_flit  [PORTS];
   dii_flit_t lout_flit [PORTS];

   // Per-router ring inputs and outputs.
   dii_flit_t        rin0_flit [PORTS];
   dii_flit_t        rin1_flit [PORTS];
   dii_flit_t        rout0_flit [PORTS];
   dii_flit_t        rout1_flit [PORTS];
   logic [PORTS-1:0] rin0_valid, rin0_ready, rin1_valid, rin1_ready;
   logic [PORTS-1:0] rout0_valid, rout0_ready, rout1_valid, rout1_ready;

   assign rout1_ready[PORTS-1] = 1'b1; // Misaddressed packets die here.

   for (genvar i = 0; i < PORTS; i++) begin : g_port
      assign lin_flit[i] = '{data: in_data[i*W +: W], first: in_first[i], last: in_last[i]};
      assign out_data[i*W +: W] = lout_flit[i].data;
      assign out_first[i]       = lout_flit[i].first;
      assign out_last[i]        = lout_flit[i].last;

      if (i == 0) begin : g_head
         assign rin0_flit[0]  = '0; // Nothing enters ring 0 from behind.
         assign rin0_valid[0] = 1'b0;
         // Second lap starts where ring 0 ends.
         assign rin1_flit[0]          = rout0_flit[PORTS-1];
         assign rin1_valid[0]         = rout0_valid[PORTS-1];
         assign rout0_ready[PORTS-1]  = rin1_ready[0];
      end else begin : g_chain
         assign rin0_flit[i]    = rout0_flit[i-1];
         assign rin0_valid[i]   = rout0_valid[i-1];
         assign rout0_ready[i-1] = rin0_ready[i];
         assign rin1_flit[i]    = rout1_flit[i-1];
         assign rin1_valid[i]   = rout1_valid[i-1];
         assign rout1_ready[i-1] = rin1_ready[i];
      end

      ring_router #(
         .ROUTER_ID   (dii_id_t'(i)),
         .BUFFER_SIZE (BUFFER_SIZE))
      u_router (
         .clk, .rst_n,
         .ring_in0_flit   (rin0_flit[i]),  .ring_in0_valid  (rin0_valid[i]),
         .ring_in0_ready  (rin0_ready[i]),
         .ring_in1_flit   (rin1_flit[i]),  .ring_in1_valid  (rin1_valid[i]),
         .ring_in1_ready  (rin1_ready[i]),
         .ring_out0_flit  (rout0_flit[i]), .ring_out0_valid (rout0_valid[i]),
         .ring_out0_ready (rout0_ready[i]),
         .ring_out1_flit  (rout1_flit[i]), .ring_out1_valid (rout1_valid[i]),
         .ring_out1_ready (rout1_ready[i]),
         .local_in_flit   (lin_flit[i]),   .local_in_valid  (in_valid[i]),
         .local_in_ready  (in_ready[i]),
         .local_out_flit  (lout_flit[i]),  .local_out_valid (out_valid[i]),
         .local_out_ready (out_ready[i]));
   end

endmodule : debug_ring

`default_nettype wire

// ==== rtl/dii_consts.svh ====
`ifndef DII_CONSTS_SVH
`define DII_CONSTS_SVH

// Flit payload and header field widths.
`define DII_FLIT_WIDTH   16
`define DII_ID_WIDTH     10

`define DII_BUFFER_DEPTH 4 // Default flits per router input.

`endif

// ==== rtl/dii_pkg.sv ====
`default_nettype none

`include "dii_consts.svh"

package dii_pkg;

   // One flit on a ring link.
   typedef struct packed {
      logic [`DII_FLIT_WIDTH-1:0] data;
      logic                       first; // Header flit.
      logic                       last;  // Tail flit.
   } dii_flit_t;

   // Router id, or the destination field of a header.
   typedef logic [`DII_ID_WIDTH-1:0] dii_id_t;

endpackage : dii_pkg

`default_nettype wire

// ==== rtl/flit_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dii_consts.svh"

module flit_buffer
   import dii_pkg::*;
   #(parameter int DEPTH = `DII_BUFFER_DEPTH)
   (input  wire logic      clk,
    input  wire logic      rst_n,

    input  wire dii_flit_t in_flit,
    input  wire logic      in_valid,
    output logic           in_ready,

    output dii_flit_t      out_flit,
    output logic           out_valid,
    input  wire logic      out_ready);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   dii_flit_t        mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count; // Occupancy.
   logic             wr_en;
   logic             rd_en;

   // Pointers wrap at DEPTH, which need not be a power of two.
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_flit  = mem[rd_ptr]; // Head comes straight from storage.

   assign wr_en = in_valid & in_ready;
   assign rd_en = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // Simultaneous push and pop leave the count alone.
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule : flit_buffer

`default_nettype wire

// ==== rtl/packet_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_arbiter
   import dii_pkg::*;
   (input  wire logic      clk,
    input  wire logic      rst_n,

    input  wire dii_flit_t a_flit,
    input  wire logic      a_valid,
    output logic           a_ready,

    input  wire dii_flit_t b_flit,
    input  wire logic      b_valid,
    output logic           b_ready,

    output dii_flit_t      out_flit,
    output logic           out_valid,
    input  wire logic      out_ready);

   typedef enum logic {
      idle,
      locked
   } state_t;

   state_t state;
   logic   last_b_q; // Set when b was granted most recently.
   logic   grant_b;
   logic   xfer;

   // While locked the owner of the current packet keeps the output.
   always_comb begin
      if (state == locked) begin
         grant_b = last_b_q;
      end else if (a_valid && b_valid) begin
         grant_b = ~last_b_q; // Round robin.
      end else begin
         grant_b = b_valid;
      end
   end

   assign out_flit  = grant_b ? b_flit : a_flit;
   assign out_valid = grant_b ? b_valid : a_valid;
   assign a_ready   = out_ready & ~grant_b;
   assign b_ready   = out_ready & grant_b;

   assign xfer = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= idle;
         last_b_q <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (xfer) begin
                  last_b_q <= grant_b;
                  if (!out_flit.last) begin
                     state <= locked;
                  end
               end
            end
            locked: begin
               // Grant is re-chosen the cycle after the tail.
               if (xfer && out_flit.last) begin
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule : packet_arbiter

`default_nettype wire

// ==== rtl/packet_route_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dii_consts.svh"

module packet_route_decoder
   import dii_pkg::*;
   #(parameter dii_id_t ROUTER_ID = '0)
   (input  wire logic      clk,
    input  wire logic      rst_n,

    input  wire dii_flit_t in_flit,
    input  wire logic      in_valid,
    output logic           in_ready,

    output dii_flit_t      local_flit,
    output logic           local_valid,
    input  wire logic      local_ready,

    output dii_flit_t      pass_flit,
    output logic           pass_valid,
    input  wire logic      pass_ready);

   typedef enum logic {
      idle,
      in_packet
   } state_t;

   state_t state;
   logic   route_local_q; // Route of the packet in flight.
   logic   hdr_local;
   logic   sel_local;
   logic   xfer;

   // Destination sits in the low bits of the header.
   assign hdr_local = (in_flit.data[`DII_ID_WIDTH-1:0] == ROUTER_ID);
   assign sel_local = (state == idle) ? hdr_local : route_local_q;

   assign local_flit  = in_flit;
   assign pass_flit   = in_flit;
   assign local_valid = in_valid & sel_local;
   assign pass_valid  = in_valid & ~sel_local;
   assign in_ready    = sel_local ? local_ready : pass_ready;

   assign xfer = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state         <= idle;
         route_local_q <= 1'b0;
      end else begin
         case (state)
            idle: begin
               // Single-flit packets never leave idle.
               if (xfer && !in_flit.last) begin
                  state         <= in_packet;
                  route_local_q <= hdr_local;
               end
            end
            in_packet: begin
               if (xfer && in_flit.last) begin
                  state <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule : packet_route_decoder

`default_nettype wire

// ==== rtl/ring_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dii_consts.svh"

module ring_router
   import dii_pkg::*;
   #(parameter dii_id_t ROUTER_ID   = '0,
     parameter int      BUFFER_SIZE = `DII_BUFFER_DEPTH)
   (input  wire logic      clk,
    input  wire logic      rst_n,

    input  wire dii_flit_t ring_in0_flit,
    input  wire logic      ring_in0_valid,
    output wire logic      ring_in0_ready,

    input  wire dii_flit_t ring_in1_flit,
    input  wire logic      ring_in1_valid,
    output wire logic      ring_in1_ready,

    output wire dii_flit_t ring_out0_flit,
    output wire logic      ring_out0_valid,
    input  wire logic      ring_out0_ready,

    output wire dii_flit_t ring_out1_flit,
    output wire logic      ring_out1_valid,
    input  wire logic      ring_out1_ready,

    input  wire dii_flit_t local_in_flit,
    input  wire logic      local_in_valid,
    output wire logic      local_in_ready,

    output wire dii_flit_t local_out_flit,
    output wire logic      local_out_valid,
    input  wire logic      local_out_ready);

   dii_flit_t buf0_flit, bufl_flit, buf1_flit;
   logic      buf0_valid, bufl_valid, buf1_valid;
   logic      buf0_ready, bufl_ready, buf1_ready;

   dii_flit_t loc0_flit, pass0_flit, loc1_flit;
   logic      loc0_valid, pass0_valid, loc1_valid;
   logic      loc0_ready, pass0_ready, loc1_ready;

   flit_buffer #(.DEPTH(BUFFER_SIZE)) u_buf_ring0 (
      .clk, .rst_n,
      .in_flit   (ring_in0_flit),  .in_valid  (ring_in0_valid), .in_ready  (ring_in0_ready),
      .out_flit  (buf0_flit),      .out_valid (buf0_valid),     .out_ready (buf0_ready));

   flit_buffer #(.DEPTH(BUFFER_SIZE)) u_buf_local (
      .clk, .rst_n,
      .in_flit   (local_in_flit),  .in_valid  (local_in_valid), .in_ready  (local_in_ready),
      .out_flit  (bufl_flit),      .out_valid (bufl_valid),     .out_ready (bufl_ready));

   flit_buffer #(.DEPTH(BUFFER_SIZE)) u_buf_ring1 (
      .clk, .rst_n,
      .in_flit   (ring_in1_flit),  .in_valid  (ring_in1_valid), .in_ready  (ring_in1_ready),
      .out_flit  (buf1_flit),      .out_valid (buf1_valid),     .out_ready (buf1_ready));

   // Ring 0 either delivers here or continues.
   packet_route_decoder #(.ROUTER_ID(ROUTER_ID)) u_dec_ring0 (
      .clk, .rst_n,
      .in_flit    (buf0_flit),  .in_valid    (buf0_valid),  .in_ready    (buf0_ready),
      .local_flit (loc0_flit),  .local_valid (loc0_valid),  .local_ready (loc0_ready),
      .pass_flit  (pass0_flit), .pass_valid  (pass0_valid), .pass_ready  (pass0_ready));

   // Ring 1 pass traffic leaves unarbitrated.
   packet_route_decoder #(.ROUTER_ID(ROUTER_ID)) u_dec_ring1 (
      .clk, .rst_n,
      .in_flit    (buf1_flit),      .in_valid    (buf1_valid),      .in_ready    (buf1_ready),
      .local_flit (loc1_flit),      .local_valid (loc1_valid),      .local_ready (loc1_ready),
      .pass_flit  (ring_out1_flit), .pass_valid  (ring_out1_valid), .pass_ready  (ring_out1_ready));

   // Through traffic shares ring 0 with injection.
   packet_arbiter u_arb_ring0 (
      .clk, .rst_n,
      .a_flit   (pass0_flit),     .a_valid   (pass0_valid),     .a_ready   (pass0_ready),
      .b_flit   (bufl_flit),      .b_valid   (bufl_valid),      .b_ready   (bufl_ready),
      .out_flit (ring_out0_flit), .out_valid (ring_out0_valid), .out_ready (ring_out0_ready));

   packet_arbiter u_arb_local (
      .clk, .rst_n,
      .a_flit   (loc0_flit),      .a_valid   (loc0_valid),      .a_ready   (loc0_ready),
      .b_flit   (loc1_flit),      .b_valid   (loc1_valid),      .b_ready   (loc1_ready),
      .out_flit (local_out_flit), .out_valid (local_out_valid), .out_ready (local_out_ready));

endmodule : ring_router

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the debug ring testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module tb_debug_ring -Mdir "$BUILD_DIR" -f sources.f; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_debug_ring" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi

// ==== sources.f ====
+incdir+rtl
rtl/dii_pkg.sv
rtl/flit_buffer.sv
rtl/packet_route_decoder.sv
rtl/packet_arbiter.sv
rtl/ring_router.sv
rtl/debug_ring.sv
verification/tb_debug_ring.sv

// ==== verification/tb_debug_ring.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dii_consts.svh"

module tb_debug_ring
   import dii_pkg::*;
   ();

   localparam int PORTS          = 4;
   localparam int FW             = `DII_FLIT_WIDTH;
   localparam int IDW            = `DII_ID_WIDTH;
   localparam int SRC_W          = FW - IDW;
   localparam int RAND_PKTS      = 40; // Per port, random phase.
   localparam int TOTAL_PKTS     = 3 * PORTS * PORTS + 3 * PORTS + RAND_PKTS * PORTS;
   localparam int CYCLES_PER_PKT = 40;
   localparam int DRAIN_CYCLES   = 400;

   logic                clk = 1'b0;
   logic                rst_n;
   logic [PORTS*FW-1:0] in_data;
   logic [PORTS-1:0]    in_valid, in_first, in_last, in_ready;
   logic [PORTS*FW-1:0] out_data;
   logic [PORTS-1:0]    out_valid, out_first, out_last, out_ready;

   dii_flit_t        tx_q [PORTS][$];        // Flits waiting to enter each port.
   dii_flit_t        exp_q [PORTS*PORTS][$]; // Indexed by src*PORTS + dst.
   logic [PORTS-1:0] took    = '0;
   logic [PORTS-1:0] in_pkt  = '0;
   int               cur_src [PORTS] = '{default: -1};
   logic             stall_en = 1'b0;
   logic [31:0]      lfsr_state = 32'h88b8_1033;

   debug_ring #(.PORTS(PORTS), .BUFFER_SIZE(4)) u_dut (
      .clk, .rst_n,
      .in_data, .in_valid, .in_first, .in_last, .in_ready,
      .out_data, .out_valid, .out_first, .out_last, .out_ready);

   always #10 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit.
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[14:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic int pending_tx();
      int n;
      n = 0;
      for (int p = 0; p < PORTS; p++) n += tx_q[p].size();
      return n;
   endfunction

   function automatic int pending_rx();
      int n;
      n = 0;
      for (int i = 0; i < PORTS * PORTS; i++) n += exp_q[i].size();
      return n;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   // Header carries source above the destination field.
   task automatic send_packet(input int src, input int dst, input int len);
      dii_flit_t f;
      for (int k = 0; k < len; k++) begin
         f.data  = (k == 0) ? {SRC_W'(src), IDW'(dst)} : rand_bits(16);
         f.first = (k == 0);
         f.last  = (k == len - 1);
         tx_q[src].push_back(f);
         if (dst < PORTS) exp_q[src*PORTS + dst].push_back(f);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (pending_tx() != 0) @(negedge clk);
      while (pending_rx() != 0 && n < DRAIN_CYCLES) begin
         @(negedge clk);
         n++;
      end
   endtask

   task automatic check_output(input int d);
      dii_flit_t got;
      dii_flit_t want;
      int        src;
      got.data  = out_data[d*FW +: FW];
      got.first = out_first[d];
      got.last  = out_last[d];
      if (got.first) begin
         assert (!in_pkt[d])
            else abort_run($sformatf("Packet interleaved with another at output port %0d", d));
         assert (got.data[IDW-1:0] == IDW'(d))
            else abort_run($sformatf("[FAIL] out_data[%0d] header dest %h, expected %h",
                                     d, got.data[IDW-1:0], IDW'(d)));
         cur_src[d] = int'(got.data[FW-1:IDW]);
      end else begin
         assert (in_pkt[d])
            else abort_run($sformatf("Flit without a header at output port %0d", d));
      end
      src = cur_src[d];
      assert (src >= 0 && src < PORTS && exp_q[src*PORTS + d].size() != 0)
         else abort_run($sformatf("Unexpected flit at output port %0d from source %0d",
                                  d, src));
      want = exp_q[src*PORTS + d].pop_front();
      assert (got == want)
         else abort_run($sformatf("[FAIL] {out_data,out_first,out_last}[%0d] %h, expected %h",
                                  d, got, want));
      in_pkt[d] = !got.last;
   endtask

   // Outputs and handshakes are sampled just before each rising edge.
   always @(posedge clk) begin
      took = in_valid & in_ready;
      if (rst_n) begin
         for (int d = 0; d < PORTS; d++) begin
            if (out_valid[d] && out_ready[d]) check_output(d);
         end
      end
   end

   always @(negedge clk) begin
      dii_flit_t cur;
      for (int p = 0; p < PORTS; p++) begin
         if (took[p]) void'(tx_q[p].pop_front());
         if (tx_q[p].size() != 0) begin
            cur                 = tx_q[p][0];
            in_data[p*FW +: FW] = cur.data;
            in_first[p]         = cur.first;
            in_last[p]          = cur.last;
            in_valid[p]         = 1'b1;
         end else begin
            in_valid[p] = 1'b0;
         end
         out_ready[p] = stall_en ? (rand_bits(1) != 16'd0) : 1'b1;
      end
   end

   initial begin
      repeat (TOTAL_PKTS * CYCLES_PER_PKT) @(posedge clk);
      abort_run("Watchdog expired before all traffic drained");
   end

   initial begin
      int len;
      int dst;
      rst_n     = 1'b0;
      in_data   = '0;
      in_valid  = '0;
      in_first  = '0;
      in_last   = '0;
      out_ready = '1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      assert (out_valid == '0)
         else abort_run($sformatf("[FAIL] out_valid %h during reset, expected 0", out_valid));
      rst_n = 1'b1;
      @(negedge clk);
      assert (out_valid == '0 && in_ready == '1)
         else abort_run($sformatf("[FAIL] out_valid %h in_ready %h after reset, expected 0 %h",
                                  out_valid, in_ready, {PORTS{1'b1}}));

      // Every source to every destination, one flit each.
      @(posedge clk);
      for (int s = 0; s < PORTS; s++)
         for (int d = 0; d < PORTS; d++) send_packet(s, d, 1);
      wait_drain();
      assert (pending_rx() == 0)
         else abort_run("Single-flit packets went missing");

      @(posedge clk);
      for (int s = 0; s < PORTS; s++) begin
         for (int d = 0; d < PORTS; d++) begin
            send_packet(s, d, 4);
            send_packet(s, d, 2 + int'(rand_bits(1)));
         end
      end
      wait_drain();
      assert (pending_rx() == 0)
         else abort_run("Multi-flit packets went missing");

      // Misaddressed packets, then ordinary traffic behind them.
      @(posedge clk);
      for (int s = 0; s < PORTS; s++) begin
         send_packet(s, PORTS + s, 2);
         send_packet(s, 1023, 1);
         send_packet(s, (s + 1) % PORTS, 3);
      end
      wait_drain();
      assert (pending_rx() == 0)
         else abort_run("Traffic behind misaddressed packets went missing");

      @(posedge clk);
      stall_en = 1'b1;
      for (int k = 0; k < RAND_PKTS; k++) begin
         for (int s = 0; s < PORTS; s++) begin
            len = int'(rand_bits(2)) + 1;
            dst = (rand_bits(3) == 16'd0) ? PORTS + int'(rand_bits(4)) : int'(rand_bits(2));
            send_packet(s, dst, len);
         end
      end
      wait_drain();
      stall_en = 1'b0;

      if (pending_rx() == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         abort_run($sformatf("%0d expected flits never arrived", pending_rx()));
      end
   end

endmodule : tb_debug_ring

`default_nettype wire
